// File: logic/mem_config.svh
// macros for word width, RAM depth and RAM latency
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// width of a RAM word and of every cache data word
`define MEM_WORD_W 32

// number of words in the RAM
// word addresses wrap modulo this depth
`define MEM_RAM_DEPTH 256

// BUSY cycles the RAM spends before its ACCESS cycle
`define MEM_RAM_LATENCY 2

`endif

// File: logic/cpu_types_pkg.sv
// memory-side types: word, RAM state and core index
`default_nettype none

`include "mem_config.svh"

package cpu_types_pkg;

  // one RAM or cache word
  typedef logic [`MEM_WORD_W-1:0] word_t;

  // RAM handshake state, ACCESS lasts one cycle
  typedef enum logic [1:0]
  {
    FREE,
    BUSY,
    ACCESS
  } ramstate_t;

  typedef logic core_t;  // index of one of the two cores

endpackage

`default_nettype wire

// File: logic/coherence_pkg.sv
// transaction types: operation kind and job record
`default_nettype none

package coherence_pkg;
  import cpu_types_pkg::*;

  // what a job does on the RAM
  typedef enum logic [1:0]
  {
    OP_WRITE,  // data store or dirty writeback
    OP_LOAD,   // data load
    OP_INSTR,  // instruction fetch
    OP_SNOOP   // coherence miss, resolved before it reaches the RAM
  } mem_op_t;

  // one job as it moves down the pipeline
  typedef struct packed
  {
    mem_op_t op;
    core_t   core;   // core the job serves
    word_t   addr;   // word address
    word_t   data;   // store word
    logic    excl;   // requester wants the line exclusive
    logic    last;   // this job ends the core's request
  } mem_job_t;

endpackage

`default_nettype wire

// File: logic/mem_job_if.sv
// interface carrying one job between pipeline stages
`timescale 1ns/1ns
`default_nettype none

interface mem_job_if
  import coherence_pkg::*;
();

  logic     valid;  // one-cycle strobe, only while busy is low
  mem_job_t job;
  logic     busy;   // destination holds a job

  modport src
  (
    output valid,
    output job,
    input  busy
  );

  modport dst
  (
    input  valid,
    input  job,
    output busy
  );

endinterface

`default_nettype wire

// File: logic/ram_if.sv
// interface between the RAM sequencer and the RAM
`timescale 1ns/1ns
`default_nettype none

interface ram_if
  import cpu_types_pkg::*;
();

  logic      ren;
  logic      wen;
  word_t     addr;
  word_t     store;
  word_t     load;   // valid in the ACCESS cycle
  ramstate_t state;

  // request held until state shows ACCESS
  modport ctrl
  (
    output ren,
    output wen,
    output addr,
    output store,
    input  load,
    input  state
  );

  modport mem
  (
    input  ren,
    input  wen,
    input  addr,
    input  store,
    output load,
    output state
  );

endinterface

`default_nettype wire

// File: logic/request_arbiter.sv
// request arbiter: fixed priority, fetch LRU and per-core pending bits
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module request_arbiter
  import cpu_types_pkg::*, coherence_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  logic [1:0]  iREN,
  input  logic [1:0]  dREN,
  input  logic [1:0]  dWEN,
  input  logic [1:0]  cctrans,
  input  logic [1:0]  ccwrite,
  input  word_t [1:0] iaddr,
  input  word_t [1:0] daddr,
  input  word_t [1:0] dstore,
  input  logic        done,
  input  core_t       done_core,
  mem_job_if.src      out
);

  logic [1:0] pending;     // core has a job in flight
  logic [1:0] snoop_pend;  // core has a snoop in flight
  logic       lru;         // fetch winner on a tie
  logic       valid_q;
  mem_job_t   job_q;

  logic [1:0] free_core;
  logic       tie;         // both free cores fetch at once
  core_t      fetch_core;
  logic       grant;
  logic       issue;
  mem_job_t   grant_job;

  function automatic mem_job_t make_job(mem_op_t op, core_t core, word_t addr,
                                        word_t data, logic excl);
    mem_job_t j;
    j.op   = op;
    j.core = core;
    j.addr = addr;
    j.data = data;
    j.excl = excl;
    j.last = 1'b1;  // arbiter jobs always close the request
    return j;
  endfunction

  always_comb
  begin
    free_core  = ~pending;
    tie        = free_core[0] && free_core[1] && iREN[0] && iREN[1];
    fetch_core = tie ? core_t'(lru) : core_t'(!(free_core[0] && iREN[0]));
    grant      = 1'b1;
    grant_job  = make_job(OP_LOAD, 1'b0, {`MEM_WORD_W{1'b0}}, {`MEM_WORD_W{1'b0}}, 1'b0);

    // a peer answering a snoop also raises cctrans, so one snoop at a time
    if (free_core[0] && dWEN[0])
      grant_job = make_job(OP_WRITE, 1'b0, daddr[0], dstore[0], 1'b0);
    else if (free_core[0] && cctrans[0] && snoop_pend == 2'b00)
      grant_job = make_job(OP_SNOOP, 1'b0, daddr[0], dstore[0], ccwrite[0]);
    else if (free_core[1] && dWEN[1])
      grant_job = make_job(OP_WRITE, 1'b1, daddr[1], dstore[1], 1'b0);
    else if (free_core[1] && cctrans[1] && snoop_pend == 2'b00)
      grant_job = make_job(OP_SNOOP, 1'b1, daddr[1], dstore[1], ccwrite[1]);
    else if (free_core[0] && dREN[0])
      grant_job = make_job(OP_LOAD, 1'b0, daddr[0], dstore[0], 1'b0);
    else if (free_core[1] && dREN[1])
      grant_job = make_job(OP_LOAD, 1'b1, daddr[1], dstore[1], 1'b0);
    else if ((free_core & iREN) != 2'b00)
      grant_job = make_job(OP_INSTR, fetch_core, iaddr[fetch_core], {`MEM_WORD_W{1'b0}}, 1'b0);
    else
      grant = 1'b0;
  end

  // never two strobes in a row, the next stage raises busy a cycle late
  assign issue = grant && !valid_q && !out.busy;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      pending    <= 2'b00;
      snoop_pend <= 2'b00;
      lru        <= 1'b0;
      valid_q    <= 1'b0;
    end
    else
    begin
      valid_q <= issue;
      if (done)
      begin
        pending[done_core]    <= 1'b0;
        snoop_pend[done_core] <= 1'b0;
      end
      if (issue)
      begin
        pending[grant_job.core] <= 1'b1;
        if (grant_job.op == OP_SNOOP)
          snoop_pend[grant_job.core] <= 1'b1;
        if (tie && grant_job.op == OP_INSTR)
          lru <= !lru;  // point away from the fetch just granted
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (issue)
      job_q <= grant_job;
  end

  assign out.valid = valid_q;
  assign out.job   = job_q;

  // a core gets no second job before its done comes back from the sequencer
  a_no_double_issue: assert property (@(posedge CLK) disable iff (!nRST)
    out.valid |-> ($past(pending) & (2'b01 << out.job.core)) == 2'b00)
    else $error("job issued for a core with a job in flight");

endmodule

`default_nettype wire

// File: logic/snoop_resolver.sv
// snoop resolver: peer snoop handshake, writeback and load job split
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module snoop_resolver
  import cpu_types_pkg::*, coherence_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  logic [1:0]  cctrans,
  input  logic [1:0]  ccwrite,
  input  word_t [1:0] dstore,
  output logic [1:0]  ccwait,
  output logic [1:0]  ccinv,
  output word_t [1:0] ccsnoopaddr,
  mem_job_if.dst      in,
  mem_job_if.src      out
);

  typedef enum logic [2:0]
  {
    S_IDLE,
    S_FWD,    // pass a plain job on
    S_SNOOP,  // peer stalled, waiting for its answer
    S_WB,     // emit the dirty writeback
    S_LOAD    // emit the requester's load
  } snoop_state_t;

  snoop_state_t state;
  mem_job_t     job_q;
  word_t        wb_data;       // peer's dirty word
  logic [1:0]   ccwait_q;
  word_t [1:0]  snoop_addr_q;
  mem_job_t     out_job;
  core_t        peer;
  logic         fire;          // out.valid this cycle

  assign peer    = ~job_q.core;
  assign in.busy = (state != S_IDLE);
  assign fire    = (state == S_FWD || state == S_WB || state == S_LOAD) && !out.busy;

  always_comb
  begin
    out_job = job_q;
    if (state == S_WB)
    begin
      out_job.op   = OP_WRITE;
      out_job.core = peer;
      out_job.data = wb_data;
      out_job.excl = 1'b0;
      out_job.last = 1'b0;  // requester still waits for its load
    end
    else if (state == S_LOAD)
    begin
      out_job.op   = OP_LOAD;
      out_job.last = 1'b1;
    end
  end

  assign out.valid = fire;
  assign out.job   = out_job;

  always_comb
  begin
    ccinv = 2'b00;
    if (state == S_LOAD && fire && job_q.excl)
      ccinv[peer] = 1'b1;  // one cycle, with the load strobe
  end

  assign ccwait      = ccwait_q;
  assign ccsnoopaddr = snoop_addr_q;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      state        <= S_IDLE;
      ccwait_q     <= 2'b00;
      snoop_addr_q <= {2{{`MEM_WORD_W{1'b0}}}};
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          if (in.valid && in.job.op == OP_SNOOP)
          begin
            state                      <= S_SNOOP;
            ccwait_q[~in.job.core]     <= 1'b1;
            snoop_addr_q[~in.job.core] <= in.job.addr;
          end
          else if (in.valid)
            state <= S_FWD;
        end
        S_FWD:
        begin
          if (fire)
            state <= S_IDLE;
        end
        S_SNOOP:
        begin
          if (cctrans[peer])
            state <= ccwrite[peer] ? S_WB : S_LOAD;  // dirty copy goes back first
        end
        S_WB:
        begin
          if (fire)
            state <= S_LOAD;
        end
        S_LOAD:
        begin
          if (fire)
          begin
            state    <= S_IDLE;
            ccwait_q <= 2'b00;  // snoop over, release the peer
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (state == S_IDLE && in.valid)
      job_q <= in.job;
    if (state == S_SNOOP && cctrans[peer])
      wb_data <= dstore[peer];
  end

  a_one_snoop: assert property (@(posedge CLK) disable iff (!nRST)
    !(ccwait[0] && ccwait[1]))
    else $error("both caches stalled by a snoop");

  a_inv_in_snoop: assert property (@(posedge CLK) disable iff (!nRST)
    (ccinv & ~ccwait) == 2'b00)
    else $error("invalidate sent outside a snoop");

endmodule

`default_nettype wire

// File: logic/ram_sequencer.sv
// RAM sequencer: one job on the RAM, wait strobes and load words
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module ram_sequencer
  import cpu_types_pkg::*, coherence_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  mem_job_if.dst      in,
  ram_if.ctrl         ram,
  output logic [1:0]  iwait,
  output logic [1:0]  dwait,
  output word_t [1:0] iload,
  output word_t [1:0] dload,
  output logic        done,
  output core_t       done_core
);

  logic     active;  // a job owns the RAM
  mem_job_t job;
  logic     fin;     // ACCESS cycle of the current job

  assign in.busy = active;
  assign fin     = active && (ram.state == ACCESS);

  assign ram.ren   = active && (job.op != OP_WRITE);
  assign ram.wen   = active && (job.op == OP_WRITE);
  assign ram.addr  = job.addr;
  assign ram.store = job.data;

  // writeback jobs without last leave the requester waiting
  assign done      = fin && job.last;
  assign done_core = job.core;

  always_comb
  begin
    for (int c = 0; c < 2; c++)
    begin
      iwait[c] = !(done && job.core == core_t'(c) && job.op == OP_INSTR);
      dwait[c] = !(done && job.core == core_t'(c) && job.op != OP_INSTR);
    end
  end

  assign iload[0] = ram.load;
  assign iload[1] = ram.load;
  assign dload[0] = ram.load;
  assign dload[1] = ram.load;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      active <= 1'b0;
    else if (fin)
      active <= 1'b0;
    else if (in.valid)
      active <= 1'b1;
  end

  always_ff @(posedge CLK)
  begin
    if (!active && in.valid)
      job <= in.job;
  end

  a_one_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(ram.ren && ram.wen))
    else $error("RAM read and write at once");

  // RAM sits BUSY for the configured latency, then ACCESS
  a_ram_timing: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(active) |-> ##(`MEM_RAM_LATENCY + 1) (ram.state == ACCESS))
    else $error("RAM ACCESS not on time");

endmodule

`default_nettype wire

// File: logic/ram_model.sv
// word RAM with fixed BUSY latency and one ACCESS cycle
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module ram_model
  import cpu_types_pkg::*;
(
  input logic CLK,
  input logic nRST,
  ram_if.mem  port
);

  localparam int ADDR_W = $clog2(`MEM_RAM_DEPTH);
  localparam int CNT_W  = $clog2(`MEM_RAM_LATENCY + 1);

  word_t             mem [`MEM_RAM_DEPTH];
  ramstate_t         state;
  logic [CNT_W-1:0]  busy_cnt;  // BUSY cycles seen so far
  logic [ADDR_W-1:0] idx;
  logic              req;

  assign req        = port.ren || port.wen;
  assign idx        = port.addr[ADDR_W-1:0];  // word address modulo depth
  assign port.state = state;
  assign port.load  = mem[idx];

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      state    <= FREE;
      busy_cnt <= '0;
      for (int i = 0; i < `MEM_RAM_DEPTH; i++)
      begin
        mem[i] <= '0;
      end
    end
    else
    begin
      case (state)
        FREE:
        begin
          if (req)
          begin
            state    <= BUSY;
            busy_cnt <= CNT_W'(1);
          end
        end
        BUSY:
        begin
          if (!req)
            state <= FREE;  // request withdrawn
          else if (busy_cnt == CNT_W'(`MEM_RAM_LATENCY))
            state <= ACCESS;
          else
            busy_cnt <= busy_cnt + CNT_W'(1);
        end
        ACCESS:
        begin
          if (port.wen)
            mem[idx] <= port.store;
          state <= FREE;
        end
        default: state <= FREE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/memory_control.sv
// memory controller top: arbiter, snoop resolver, RAM sequencer and RAM
`timescale 1ns/1ns
`default_nettype none

module memory_control
  import cpu_types_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  logic [1:0]  iREN,
  input  logic [1:0]  dREN,
  input  logic [1:0]  dWEN,
  input  word_t [1:0] iaddr,
  input  word_t [1:0] daddr,
  input  word_t [1:0] dstore,
  output logic [1:0]  iwait,
  output logic [1:0]  dwait,
  output word_t [1:0] iload,
  output word_t [1:0] dload,
  input  logic [1:0]  cctrans,
  input  logic [1:0]  ccwrite,
  output logic [1:0]  ccwait,
  output logic [1:0]  ccinv,
  output word_t [1:0] ccsnoopaddr
);

  logic  done;       // last job of a request finished
  core_t done_core;

  mem_job_if arb_to_snoop ();
  mem_job_if snoop_to_seq ();
  ram_if     ram_bus ();

  request_arbiter u_arbiter
  (
    .CLK       (CLK),
    .nRST      (nRST),
    .iREN      (iREN),
    .dREN      (dREN),
    .dWEN      (dWEN),
    .cctrans   (cctrans),
    .ccwrite   (ccwrite),
    .iaddr     (iaddr),
    .daddr     (daddr),
    .dstore    (dstore),
    .done      (done),
    .done_core (done_core),
    .out       (arb_to_snoop.src)
  );

  snoop_resolver u_snoop
  (
    .CLK         (CLK),
    .nRST        (nRST),
    .cctrans     (cctrans),
    .ccwrite     (ccwrite),
    .dstore      (dstore),
    .ccwait      (ccwait),
    .ccinv       (ccinv),
    .ccsnoopaddr (ccsnoopaddr),
    .in          (arb_to_snoop.dst),
    .out         (snoop_to_seq.src)
  );

  ram_sequencer u_sequencer
  (
    .CLK       (CLK),
    .nRST      (nRST),
    .in        (snoop_to_seq.dst),
    .ram       (ram_bus.ctrl),
    .iwait     (iwait),
    .dwait     (dwait),
    .iload     (iload),
    .dload     (dload),
    .done      (done),
    .done_core (done_core)
  );

  ram_model u_ram
  (
    .CLK  (CLK),
    .nRST (nRST),
    .port (ram_bus.mem)
  );

endmodule

`default_nettype wire

// File: bench/memory_control_tb.sv
// testbench for the memory controller: clock, reset, cache drivers, directed tests, scoreboard
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module memory_control_tb
  import cpu_types_pkg::*;
();

  localparam int PERIOD = 40;
  localparam int DEPTH  = `MEM_RAM_DEPTH;
  // about 65 requests of under 15 cycles each, so 4000 leaves a wide margin
  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] SEED = 32'h768c_5bf5;

  logic        CLK;
  logic        nRST;
  logic [1:0]  iREN;
  logic [1:0]  dREN;
  logic [1:0]  dWEN;
  logic [1:0]  cctrans;
  logic [1:0]  ccwrite;
  word_t [1:0] iaddr;
  word_t [1:0] daddr;
  word_t [1:0] dstore;
  logic [1:0]  iwait;
  logic [1:0]  dwait;
  logic [1:0]  ccwait;
  logic [1:0]  ccinv;
  word_t [1:0] iload;
  word_t [1:0] dload;
  word_t [1:0] ccsnoopaddr;

  word_t       scoreboard [DEPTH];  // expected RAM contents
  int unsigned cycle_count = 0;

  memory_control uut (.*);

  initial CLK = 1'b0;
  always #(PERIOD / 2) CLK = ~CLK;

  always @(posedge CLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic int sb_index(input word_t a);
    return int'(a % word_t'(DEPTH));  // RAM wraps word addresses
  endfunction

  task automatic report_error(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    assert (got === exp)
    else report_error($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  // one data request, held until dwait drops for that core
  task automatic data_access(input core_t c, input logic wr, input word_t addr,
                             input word_t wdata, output word_t rdata,
                             output int unsigned fin);
    @(posedge CLK);
    daddr[c]  <= addr;
    dstore[c] <= wdata;
    dWEN[c]   <= wr;
    dREN[c]   <= !wr;
    @(negedge CLK);
    while (dwait[c])
      @(negedge CLK);
    rdata = dload[c];  // valid in the cycle dwait is low
    fin   = cycle_count;
    @(posedge CLK);
    dWEN[c] <= 1'b0;
    dREN[c] <= 1'b0;
  endtask

  task automatic write_word(input core_t c, input word_t addr, input word_t wdata);
    word_t       unused;
    int unsigned fin;
    data_access(c, 1'b1, addr, wdata, unused, fin);
    scoreboard[sb_index(addr)] = wdata;
  endtask

  task automatic load_check(input core_t c, input word_t addr, output int unsigned fin);
    word_t got;
    data_access(c, 1'b0, addr, '0, got, fin);
    check_word($sformatf("core %0d load at %h", c, addr), got, scoreboard[sb_index(addr)]);
  endtask

  task automatic fetch_word(input core_t c, input word_t addr, output int unsigned fin);
    word_t got;
    @(posedge CLK);
    iaddr[c] <= addr;
    iREN[c]  <= 1'b1;
    @(negedge CLK);
    while (iwait[c])
      @(negedge CLK);
    got = iload[c];
    fin = cycle_count;
    check_word($sformatf("core %0d fetch at %h", c, addr), got, scoreboard[sb_index(addr)]);
    @(posedge CLK);
    iREN[c] <= 1'b0;
  endtask

  task automatic reset_state_test();
    @(negedge CLK);
    assert (iwait === 2'b11) else report_error($sformatf("iwait %b after reset", iwait));
    assert (dwait === 2'b11) else report_error($sformatf("dwait %b after reset", dwait));
    assert (ccwait === 2'b00) else report_error($sformatf("ccwait %b after reset", ccwait));
    assert (ccinv === 2'b00) else report_error($sformatf("ccinv %b after reset", ccinv));
  endtask

  task automatic write_load_test();
    int unsigned fin;
    write_word(1'b0, 32'h10, $urandom());
    write_word(1'b1, 32'h11, $urandom());
    load_check(1'b1, 32'h10, fin);  // each core reads the other's word
    load_check(1'b0, 32'h11, fin);
  endtask

  task automatic fetch_tie_test();
    int unsigned fin0;
    int unsigned fin1;
    write_word(1'b0, 32'h20, $urandom());
    write_word(1'b1, 32'h21, $urandom());
    fork
      fetch_word(1'b0, 32'h20, fin0);
      fetch_word(1'b1, 32'h21, fin1);
    join
    assert (fin0 < fin1)
    else report_error("first tied fetch: core 1 finished before core 0");
    fork
      fetch_word(1'b0, 32'h21, fin0);
      fetch_word(1'b1, 32'h20, fin1);
    join
    assert (fin1 < fin0)
    else report_error("second tied fetch: core 0 finished before core 1");
  endtask

  task automatic load_vs_fetch_test();
    int unsigned fin0;
    int unsigned fin1;
    fork
      load_check(1'b0, 32'h21, fin0);
      fetch_word(1'b1, 32'h10, fin1);
    join
    assert (fin0 < fin1)
    else report_error("core 1 fetch finished before core 0 data load");
  endtask

  task automatic snoop_test();
    word_t addr;
    word_t dirty;
    word_t got;
    logic  inv_seen;
    int unsigned fin;
    addr     = 32'h30;
    dirty    = $urandom();
    inv_seen = 1'b0;
    write_word(1'b1, addr, ~dirty);  // stale copy in RAM
    fork
      begin  // core 0 wants the line exclusive
        @(posedge CLK);
        daddr[0]   <= addr;
        dREN[0]    <= 1'b1;
        cctrans[0] <= 1'b1;
        ccwrite[0] <= 1'b1;
        @(negedge CLK);
        while (dwait[0])
          @(negedge CLK);
        got = dload[0];
        @(posedge CLK);
        dREN[0]    <= 1'b0;
        cctrans[0] <= 1'b0;
        ccwrite[0] <= 1'b0;
      end
      begin  // core 1 answers with its dirty word
        @(negedge CLK);
        while (!ccwait[1])
          @(negedge CLK);
        check_word("snoop address to core 1", ccsnoopaddr[1], addr);
        @(posedge CLK);
        cctrans[1] <= 1'b1;
        ccwrite[1] <= 1'b1;
        dstore[1]  <= dirty;
        @(negedge CLK);
        while (ccwait[1])
        begin
          if (ccinv[1])
            inv_seen = 1'b1;
          @(negedge CLK);
        end
        @(posedge CLK);
        cctrans[1] <= 1'b0;
        ccwrite[1] <= 1'b0;
      end
    join
    scoreboard[sb_index(addr)] = dirty;  // peer's writeback
    check_word("core 0 load after snoop", got, dirty);
    assert (inv_seen) else report_error("no invalidate reached core 1 during the snoop");
    assert (ccwait === 2'b00) else report_error($sformatf("ccwait %b after snoop", ccwait));
    load_check(1'b1, addr, fin);  // dirty word now in RAM
  endtask

  task automatic random_test();
    core_t c;
    word_t addr;
    int unsigned fin;
    for (int n = 0; n < 50; n++)
    begin
      c    = core_t'($urandom_range(1));
      addr = word_t'($urandom_range(15));
      if ($urandom_range(1) == 1)
        write_word(c, addr, $urandom());
      else
        load_check(c, addr, fin);
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    for (int i = 0; i < DEPTH; i++)
      scoreboard[i] = '0;  // RAM clears at reset
    nRST    <= 1'b0;
    iREN    <= 2'b00;
    dREN    <= 2'b00;
    dWEN    <= 2'b00;
    cctrans <= 2'b00;
    ccwrite <= 2'b00;
    iaddr   <= '0;
    daddr   <= '0;
    dstore  <= '0;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    reset_state_test();
    write_load_test();
    fetch_tie_test();  // needs LRU still at its reset value
    load_vs_fetch_test();
    snoop_test();
    random_test();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
logic/cpu_types_pkg.sv
logic/coherence_pkg.sv
logic/mem_job_if.sv
logic/ram_if.sv
logic/request_arbiter.sv
logic/snoop_resolver.sv
logic/ram_sequencer.sv
logic/ram_model.sv
logic/memory_control.sv
bench/memory_control_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the memory controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/1ns -f src.f \
    --top-module memory_control_tb --Mdir obj_dir -o memory_control_sim; then
  echo "error: Verilator compile failed"
  exit 1
fi

./obj_dir/memory_control_sim > sim.log 2>&1
run_status=$?
cat sim.log

if [ "$run_status" -ne 0 ]; then
  echo "error: simulation exited with status $run_status"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  echo "PASS"
  exit 0
fi

echo "FAIL: pass message not found in sim.log"
exit 1
